// File: hw/decode_pkg.sv
package decode_pkg;

    localparam int XLEN      = 32;
    localparam int REG_AW    = 5;
    localparam int NUM_REGS  = 32;
    localparam int ALU_OP_W  = 12;
    localparam int BR_KIND_W = 9;

    // one-hot alu operation bits
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // one-hot branch kind bits
    localparam int BR_BEQ  = 0;
    localparam int BR_BNE  = 1;
    localparam int BR_BLT  = 2;
    localparam int BR_BGE  = 3;
    localparam int BR_BLTU = 4;
    localparam int BR_BGEU = 5;
    localparam int BR_B    = 6;
    localparam int BR_BL   = 7;
    localparam int BR_JIRL = 8;

    // inst[31:15] of register ops and shifts by ui5
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_SLTU   = 17'h00025;
    localparam logic [16:0] OPC_NOR    = 17'h00028;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    localparam logic [16:0] OPC_SLL_W  = 17'h0002e;
    localparam logic [16:0] OPC_SRL_W  = 17'h0002f;
    localparam logic [16:0] OPC_SRA_W  = 17'h00030;
    localparam logic [16:0] OPC_SLLI_W = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W = 17'h00091;

    // inst[31:22]
    localparam logic [9:0] OPC_SLTI   = 10'h008;
    localparam logic [9:0] OPC_SLTUI  = 10'h009;
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_ANDI   = 10'h00d;
    localparam logic [9:0] OPC_ORI    = 10'h00e;
    localparam logic [9:0] OPC_XORI   = 10'h00f;
    localparam logic [9:0] OPC_LD_W   = 10'h0a2;
    localparam logic [9:0] OPC_ST_W   = 10'h0a6;

    // inst[31:26]
    localparam logic [5:0] OPC_JIRL = 6'h13;
    localparam logic [5:0] OPC_B    = 6'h14;
    localparam logic [5:0] OPC_BL   = 6'h15;
    localparam logic [5:0] OPC_BEQ  = 6'h16;
    localparam logic [5:0] OPC_BNE  = 6'h17;
    localparam logic [5:0] OPC_BLT  = 6'h18;
    localparam logic [5:0] OPC_BGE  = 6'h19;
    localparam logic [5:0] OPC_BLTU = 6'h1a;
    localparam logic [5:0] OPC_BGEU = 6'h1b;

    // inst[31:25]
    localparam logic [6:0] OPC_LU12I_W   = 7'h0a;
    localparam logic [6:0] OPC_PCADDU12I = 7'h0e;

    typedef struct packed {
        logic [16:0]       opcode;
        logic [REG_AW-1:0] rk;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]        opcode;
        logic [11:0]       i12;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [15:0]       i16;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]        opcode;
        logic [19:0]       i20;
        logic [REG_AW-1:0] rd;
    } fmt_1ri20_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    // one instruction word seen through each format
    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_2ri16_t ri16;
        fmt_1ri20_t ri20;
        fmt_i26_t   i26;
    } inst_word_u;

    typedef struct packed {
        inst_word_u      inst;
        logic [XLEN-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } rf_fwd_t;

    typedef struct packed {
        logic    load_pending;
        rf_fwd_t fwd;
    } ex_fwd_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0]  alu_op;
        logic                 src1_is_pc;
        logic                 src2_is_imm;
        logic                 src_reg_is_rd;
        logic                 rf_we;
        logic [REG_AW-1:0]    dest;
        logic                 need_r1;
        logic                 need_r2;
        logic                 is_load;
        logic                 is_store;
        logic [BR_KIND_W-1:0] br_kind;
    } dec_ctrl_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0] alu_op;
        logic [XLEN-1:0]     alu_src1;
        logic [XLEN-1:0]     alu_src2;
        logic                rf_we;
        logic [REG_AW-1:0]   dest;
        logic [XLEN-1:0]     pc;
        logic                is_load;
        logic                is_store;
        logic [XLEN-1:0]     store_data;
    } id_to_ex_t;

endpackage

// File: hw/stage_ctrl.sv
`timescale 1ns/100ps

module stage_ctrl import decode_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       i_if_valid,
    input  fetch_pkt_t i_if_pkt,
    input  logic       i_ready_go,
    input  logic       i_ex_allowin,
    input  logic       i_br_taken,
    output logic       o_id_allowin,
    output logic       o_valid,
    output logic       o_id_to_ex_valid,
    output fetch_pkt_t o_pkt
);
    logic       valid_q;
    fetch_pkt_t pkt_q;
    logic       take;

    assign o_id_allowin     = ~valid_q | (i_ready_go & i_ex_allowin);
    assign o_id_to_ex_valid = valid_q & i_ready_go;
    assign o_valid          = valid_q;
    assign o_pkt            = pkt_q;

    // fetch behind a taken branch is wrong path
    assign take = i_if_valid & o_id_allowin & ~i_br_taken;

    // stage valid moves only when allowin is high
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (o_id_allowin) begin
            valid_q <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pkt_q <= i_if_pkt;
        end
    end

    a_pkt_held: assert property (@(posedge clk) disable iff (!resetn)
        o_id_to_ex_valid && !i_ex_allowin |=> $stable(o_pkt));

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import decode_pkg::*; (
    input  inst_word_u        i_inst,
    output dec_ctrl_t         o_ctrl,
    output logic [XLEN-1:0]   o_imm,
    output logic [XLEN-1:0]   o_br_offs,
    output logic [REG_AW-1:0] o_raddr1,
    output logic [REG_AW-1:0] o_raddr2
);
    fmt_3r_t    f3r;
    fmt_2ri12_t f12;
    fmt_2ri16_t f16;
    fmt_1ri20_t f20;
    fmt_i26_t   f26;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic inst_b, inst_bl, inst_jirl;

    logic                need_ui5;
    logic                need_ui12;
    logic                need_si12;
    logic                need_si20;
    logic                src2_is_4;
    logic                is_cond_br;
    logic                src_reg_is_rd;
    logic [ALU_OP_W-1:0] alu_op;

    assign f3r = i_inst.r3;
    assign f12 = i_inst.ri12;
    assign f16 = i_inst.ri16;
    assign f20 = i_inst.ri20;
    assign f26 = i_inst.i26;

    assign inst_add_w  = (f3r.opcode == OPC_ADD_W);
    assign inst_sub_w  = (f3r.opcode == OPC_SUB_W);
    assign inst_slt    = (f3r.opcode == OPC_SLT);
    assign inst_sltu   = (f3r.opcode == OPC_SLTU);
    assign inst_nor    = (f3r.opcode == OPC_NOR);
    assign inst_and    = (f3r.opcode == OPC_AND);
    assign inst_or     = (f3r.opcode == OPC_OR);
    assign inst_xor    = (f3r.opcode == OPC_XOR);
    assign inst_sll_w  = (f3r.opcode == OPC_SLL_W);
    assign inst_srl_w  = (f3r.opcode == OPC_SRL_W);
    assign inst_sra_w  = (f3r.opcode == OPC_SRA_W);
    assign inst_slli_w = (f3r.opcode == OPC_SLLI_W);
    assign inst_srli_w = (f3r.opcode == OPC_SRLI_W);
    assign inst_srai_w = (f3r.opcode == OPC_SRAI_W);

    assign inst_slti   = (f12.opcode == OPC_SLTI);
    assign inst_sltui  = (f12.opcode == OPC_SLTUI);
    assign inst_addi_w = (f12.opcode == OPC_ADDI_W);
    assign inst_andi   = (f12.opcode == OPC_ANDI);
    assign inst_ori    = (f12.opcode == OPC_ORI);
    assign inst_xori   = (f12.opcode == OPC_XORI);
    assign inst_ld_w   = (f12.opcode == OPC_LD_W);
    assign inst_st_w   = (f12.opcode == OPC_ST_W);

    assign inst_lu12i_w   = (f20.opcode == OPC_LU12I_W);
    assign inst_pcaddu12i = (f20.opcode == OPC_PCADDU12I);

    assign inst_jirl = (f16.opcode == OPC_JIRL);
    assign inst_beq  = (f16.opcode == OPC_BEQ);
    assign inst_bne  = (f16.opcode == OPC_BNE);
    assign inst_blt  = (f16.opcode == OPC_BLT);
    assign inst_bge  = (f16.opcode == OPC_BGE);
    assign inst_bltu = (f16.opcode == OPC_BLTU);
    assign inst_bgeu = (f16.opcode == OPC_BGEU);
    assign inst_b    = (f26.opcode == OPC_B);
    assign inst_bl   = (f26.opcode == OPC_BL);

    assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    assign need_ui5   = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_ui12  = inst_andi | inst_ori | inst_xori;
    assign need_si12  = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    assign need_si20  = inst_lu12i_w | inst_pcaddu12i;
    // link value for bl and jirl
    assign src2_is_4  = inst_jirl | inst_bl;

    // address calc for ld/st and the link add share the adder
    assign alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                            | inst_jirl | inst_bl | inst_pcaddu12i;
    assign alu_op[ALU_SUB]  = inst_sub_w;
    assign alu_op[ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
    assign alu_op[ALU_AND]  = inst_and | inst_andi;
    assign alu_op[ALU_NOR]  = inst_nor;
    assign alu_op[ALU_OR]   = inst_or | inst_ori;
    assign alu_op[ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
    assign alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
    assign alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
    assign alu_op[ALU_LUI]  = inst_lu12i_w;

    always_comb begin
        if (src2_is_4) begin
            o_imm = XLEN'(4);
        end else if (need_si20) begin
            o_imm = {f20.i20, 12'b0};
        end else if (need_si12) begin
            o_imm = {{(XLEN-12){f12.i12[11]}}, f12.i12};
        end else if (need_ui5) begin
            o_imm = {{(XLEN-REG_AW){1'b0}}, f3r.rk};
        end else begin
            o_imm = {{(XLEN-12){1'b0}}, f12.i12};
        end
    end

    assign o_br_offs = (inst_b | inst_bl)
                     ? {{4{f26.offs_hi[9]}}, f26.offs_hi, f26.offs_lo, 2'b0}
                     : {{14{f16.i16[15]}}, f16.i16, 2'b0};

    assign src_reg_is_rd = is_cond_br | inst_st_w;
    assign o_raddr1      = f3r.rj;
    assign o_raddr2      = src_reg_is_rd ? f3r.rd : f3r.rk;

    always_comb begin
        o_ctrl.alu_op        = alu_op;
        o_ctrl.src1_is_pc    = inst_jirl | inst_bl | inst_pcaddu12i;
        o_ctrl.src2_is_imm   = need_ui5 | need_ui12 | need_si12 | need_si20 | src2_is_4;
        o_ctrl.src_reg_is_rd = src_reg_is_rd;
        o_ctrl.rf_we         = (|alu_op) & ~inst_st_w;
        o_ctrl.dest          = inst_bl ? REG_AW'(1) : f3r.rd;
        // jirl reads rj for its target
        o_ctrl.need_r1       = (|alu_op) & ~(inst_bl | need_si20) | is_cond_br;
        o_ctrl.need_r2       = (|alu_op) & ~o_ctrl.src2_is_imm | is_cond_br | inst_st_w;
        o_ctrl.is_load       = inst_ld_w;
        o_ctrl.is_store      = inst_st_w;
        o_ctrl.br_kind[BR_BEQ]  = inst_beq;
        o_ctrl.br_kind[BR_BNE]  = inst_bne;
        o_ctrl.br_kind[BR_BLT]  = inst_blt;
        o_ctrl.br_kind[BR_BGE]  = inst_bge;
        o_ctrl.br_kind[BR_BLTU] = inst_bltu;
        o_ctrl.br_kind[BR_BGEU] = inst_bgeu;
        o_ctrl.br_kind[BR_B]    = inst_b;
        o_ctrl.br_kind[BR_BL]   = inst_bl;
        o_ctrl.br_kind[BR_JIRL] = inst_jirl;
    end

endmodule

// File: hw/regfile.sv
`timescale 1ns/100ps

module regfile import decode_pkg::*; (
    input  logic              clk,
    input  logic [REG_AW-1:0] i_raddr1,
    input  logic [REG_AW-1:0] i_raddr2,
    input  rf_fwd_t           i_wb,
    output logic [XLEN-1:0]   o_rdata1,
    output logic [XLEN-1:0]   o_rdata2
);
    logic [XLEN-1:0] rf [NUM_REGS];

    always_ff @(posedge clk) begin
        if (i_wb.we) begin
            rf[i_wb.waddr] <= i_wb.wdata;
        end
    end

    // r0 is hardwired zero on read
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : rf[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : rf[i_raddr2];

endmodule

// File: hw/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass import decode_pkg::*; (
    input  logic [REG_AW-1:0] i_raddr1,
    input  logic [REG_AW-1:0] i_raddr2,
    input  logic              i_need_r1,
    input  logic              i_need_r2,
    input  logic [XLEN-1:0]   i_rdata1,
    input  logic [XLEN-1:0]   i_rdata2,
    input  ex_fwd_t           i_ex_fwd,
    input  rf_fwd_t           i_mem_fwd,
    input  rf_fwd_t           i_wb_fwd,
    output logic [XLEN-1:0]   o_rj_value,
    output logic [XLEN-1:0]   o_rkd_value,
    output logic              o_ready_go
);
    logic ex_hit1;
    logic ex_hit2;
    logic mem_hit1;
    logic mem_hit2;
    logic wb_hit1;
    logic wb_hit2;

    // a write to r0 never matches
    function automatic logic hit(input logic [REG_AW-1:0] ra, input rf_fwd_t f);
        return f.we && (f.waddr == ra) && (ra != '0);
    endfunction

    assign ex_hit1  = hit(i_raddr1, i_ex_fwd.fwd);
    assign ex_hit2  = hit(i_raddr2, i_ex_fwd.fwd);
    assign mem_hit1 = hit(i_raddr1, i_mem_fwd);
    assign mem_hit2 = hit(i_raddr2, i_mem_fwd);
    assign wb_hit1  = hit(i_raddr1, i_wb_fwd);
    assign wb_hit2  = hit(i_raddr2, i_wb_fwd);

    // youngest producer wins
    assign o_rj_value  = ex_hit1  ? i_ex_fwd.fwd.wdata :
                         mem_hit1 ? i_mem_fwd.wdata    :
                         wb_hit1  ? i_wb_fwd.wdata     : i_rdata1;
    assign o_rkd_value = ex_hit2  ? i_ex_fwd.fwd.wdata :
                         mem_hit2 ? i_mem_fwd.wdata    :
                         wb_hit2  ? i_wb_fwd.wdata     : i_rdata2;

    // load result not back from memory yet
    assign o_ready_go = ~(i_ex_fwd.load_pending
                          & ((ex_hit1 & i_need_r1) | (ex_hit2 & i_need_r2)));

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/100ps

module branch_unit import decode_pkg::*; (
    input  logic            i_valid,
    input  logic            i_ready_go,
    input  dec_ctrl_t       i_ctrl,
    input  logic [XLEN-1:0] i_pc,
    input  logic [XLEN-1:0] i_rj_value,
    input  logic [XLEN-1:0] i_rkd_value,
    input  logic [XLEN-1:0] i_br_offs,
    output logic            o_br_taken,
    output logic [XLEN-1:0] o_br_target
);
    localparam int NGRP = XLEN / 4;
    localparam int NSUP = NGRP / 4;

    logic [XLEN-1:0] b_inv;
    logic [XLEN-1:0] p;
    logic [XLEN-1:0] g;
    logic [XLEN-1:0] c;
    logic [XLEN-1:0] diff;
    logic [NGRP-1:0] gp;
    logic [NGRP-1:0] gg;
    logic [NGRP-1:0] gc;
    logic [NSUP-1:0] sp;
    logic [NSUP-1:0] sg;
    logic [NSUP-1:0] sc;
    logic            cout;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            cond;

    // {generate, propagate} of a 4-wide block
    function automatic logic [1:0] pg4(input logic [3:0] pp, input logic [3:0] gi);
        return {gi[3] | pp[3] & gi[2] | pp[3] & pp[2] & gi[1]
                | pp[3] & pp[2] & pp[1] & gi[0], &pp};
    endfunction

    // carry into each of the four positions
    function automatic logic [3:0] carry4(input logic [3:0] pp, input logic [3:0] gi,
                                          input logic ci);
        logic [3:0] cc;
        cc[0] = ci;
        cc[1] = gi[0] | pp[0] & ci;
        cc[2] = gi[1] | pp[1] & gi[0] | pp[1] & pp[0] & ci;
        cc[3] = gi[2] | pp[2] & gi[1] | pp[2] & pp[1] & gi[0] | pp[2] & pp[1] & pp[0] & ci;
        return cc;
    endfunction

    // rj - rkd as rj + ~rkd + 1
    assign b_inv = ~i_rkd_value;
    assign p     = i_rj_value ^ b_inv;
    assign g     = i_rj_value & b_inv;

    for (genvar k = 0; k < NGRP; k++) begin : g_grp
        assign {gg[k], gp[k]}  = pg4(p[4*k +: 4], g[4*k +: 4]);
        assign c[4*k +: 4]     = carry4(p[4*k +: 4], g[4*k +: 4], gc[k]);
    end

    for (genvar s = 0; s < NSUP; s++) begin : g_sup
        assign {sg[s], sp[s]}  = pg4(gp[4*s +: 4], gg[4*s +: 4]);
        assign gc[4*s +: 4]    = carry4(gp[4*s +: 4], gg[4*s +: 4], sc[s]);
    end

    assign sc[0] = 1'b1;
    assign sc[1] = sg[0] | sp[0];
    assign cout  = sg[1] | sp[1] & sg[0] | sp[1] & sp[0];

    assign diff = p ^ c;
    assign eq   = ~|diff;
    // sign xor overflow
    assign lt_s = diff[XLEN-1] ^ (c[XLEN-1] ^ cout);
    assign lt_u = ~cout;

    always_comb begin
        cond = i_ctrl.br_kind[BR_B] | i_ctrl.br_kind[BR_BL] | i_ctrl.br_kind[BR_JIRL];
        cond = cond | (i_ctrl.br_kind[BR_BEQ] & eq) | (i_ctrl.br_kind[BR_BNE] & ~eq);
        cond = cond | (i_ctrl.br_kind[BR_BLT] & lt_s) | (i_ctrl.br_kind[BR_BGE] & ~lt_s);
        cond = cond | (i_ctrl.br_kind[BR_BLTU] & lt_u) | (i_ctrl.br_kind[BR_BGEU] & ~lt_u);
    end

    assign o_br_taken  = i_valid & i_ready_go & cond;
    assign o_br_target = (i_ctrl.br_kind[BR_JIRL] ? i_rj_value : i_pc) + i_br_offs;

endmodule

// File: hw/decode_stage_top.sv
`timescale 1ns/100ps

module decode_stage_top import decode_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_if_valid,
    input  fetch_pkt_t      i_if_pkt,
    input  logic            i_ex_allowin,
    input  rf_fwd_t         i_wb_fwd,
    input  rf_fwd_t         i_mem_fwd,
    input  ex_fwd_t         i_ex_fwd,
    output logic            o_id_allowin,
    output logic            o_id_to_ex_valid,
    output id_to_ex_t       o_id_to_ex,
    output logic            o_br_taken,
    output logic [XLEN-1:0] o_br_target
);
    fetch_pkt_t        pkt;
    logic              valid;
    logic              ready_go;
    dec_ctrl_t         ctrl;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   br_offs;
    logic [REG_AW-1:0] raddr1;
    logic [REG_AW-1:0] raddr2;
    logic [XLEN-1:0]   rdata1;
    logic [XLEN-1:0]   rdata2;
    logic [XLEN-1:0]   rj_value;
    logic [XLEN-1:0]   rkd_value;

    stage_ctrl u_stage_ctrl (
        .clk              (clk),
        .resetn           (resetn),
        .i_if_valid       (i_if_valid),
        .i_if_pkt         (i_if_pkt),
        .i_ready_go       (ready_go),
        .i_ex_allowin     (i_ex_allowin),
        .i_br_taken       (o_br_taken),
        .o_id_allowin     (o_id_allowin),
        .o_valid          (valid),
        .o_id_to_ex_valid (o_id_to_ex_valid),
        .o_pkt            (pkt)
    );

    inst_decoder u_inst_decoder (
        .i_inst    (pkt.inst),
        .o_ctrl    (ctrl),
        .o_imm     (imm),
        .o_br_offs (br_offs),
        .o_raddr1  (raddr1),
        .o_raddr2  (raddr2)
    );

    regfile u_regfile (
        .clk      (clk),
        .i_raddr1 (raddr1),
        .i_raddr2 (raddr2),
        .i_wb     (i_wb_fwd),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    operand_bypass u_operand_bypass (
        .i_raddr1    (raddr1),
        .i_raddr2    (raddr2),
        .i_need_r1   (ctrl.need_r1),
        .i_need_r2   (ctrl.need_r2),
        .i_rdata1    (rdata1),
        .i_rdata2    (rdata2),
        .i_ex_fwd    (i_ex_fwd),
        .i_mem_fwd   (i_mem_fwd),
        .i_wb_fwd    (i_wb_fwd),
        .o_rj_value  (rj_value),
        .o_rkd_value (rkd_value),
        .o_ready_go  (ready_go)
    );

    branch_unit u_branch_unit (
        .i_valid     (valid),
        .i_ready_go  (ready_go),
        .i_ctrl      (ctrl),
        .i_pc        (pkt.pc),
        .i_rj_value  (rj_value),
        .i_rkd_value (rkd_value),
        .i_br_offs   (br_offs),
        .o_br_taken  (o_br_taken),
        .o_br_target (o_br_target)
    );

    always_comb begin
        o_id_to_ex.alu_op     = ctrl.alu_op;
        o_id_to_ex.alu_src1   = ctrl.src1_is_pc ? pkt.pc : rj_value;
        o_id_to_ex.alu_src2   = ctrl.src2_is_imm ? imm : rkd_value;
        o_id_to_ex.rf_we      = ctrl.rf_we;
        o_id_to_ex.dest       = ctrl.dest;
        o_id_to_ex.pc         = pkt.pc;
        o_id_to_ex.is_load    = ctrl.is_load;
        o_id_to_ex.is_store   = ctrl.is_store;
        o_id_to_ex.store_data = rkd_value;
    end

endmodule

// File: verification/tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage import decode_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int MAX_ROWS   = 64;
    localparam int CHK_ALU    = 1;
    localparam int CHK_BR     = 2;

    logic            clk;
    logic            resetn;
    logic            i_if_valid;
    fetch_pkt_t      i_if_pkt;
    logic            i_ex_allowin;
    rf_fwd_t         i_wb_fwd;
    rf_fwd_t         i_mem_fwd;
    ex_fwd_t         i_ex_fwd;
    logic            o_id_allowin;
    logic            o_id_to_ex_valid;
    id_to_ex_t       o_id_to_ex;
    logic            o_br_taken;
    logic [XLEN-1:0] o_br_target;

    // one entry per pattern row
    logic [31:0] p_inst   [MAX_ROWS];
    logic [31:0] p_pc     [MAX_ROWS];
    logic [37:0] p_wb     [MAX_ROWS];
    logic [37:0] p_mem    [MAX_ROWS];
    logic [38:0] p_ex     [MAX_ROWS];
    logic        p_allow  [MAX_ROWS];
    logic        e_valid  [MAX_ROWS];
    logic        e_allow  [MAX_ROWS];
    logic [3:0]  e_chk    [MAX_ROWS];
    logic [31:0] e_src1   [MAX_ROWS];
    logic [31:0] e_src2   [MAX_ROWS];
    logic [4:0]  e_dest   [MAX_ROWS];
    logic        e_taken  [MAX_ROWS];
    logic [31:0] e_target [MAX_ROWS];

    int          n_rows;
    int          n_checks;
    int          n_errors;
    logic        rows_loaded;
    id_to_ex_t   prev_pkt;
    logic        prev_held;
    logic [31:0] stage_pc;

    decode_stage_top u_dut (
        .clk              (clk),
        .resetn           (resetn),
        .i_if_valid       (i_if_valid),
        .i_if_pkt         (i_if_pkt),
        .i_ex_allowin     (i_ex_allowin),
        .i_wb_fwd         (i_wb_fwd),
        .i_mem_fwd        (i_mem_fwd),
        .i_ex_fwd         (i_ex_fwd),
        .o_id_allowin     (o_id_allowin),
        .o_id_to_ex_valid (o_id_to_ex_valid),
        .o_id_to_ex       (o_id_to_ex),
        .o_br_taken       (o_br_taken),
        .o_br_target      (o_br_target)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // start value of register i
    function automatic logic [31:0] reg_init(input int i);
        return 32'(i) * 32'h0909_0909;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] inst, pc, src1, src2, target;
        logic [37:0] wb, mem;
        logic [38:0] ex;
        logic [3:0]  allow, valid, allowin, chk, taken;
        logic [7:0]  dest;
        fd = $fopen("verification/decode_patterns.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("could not open the pattern file");
            return;
        end
        while (!$feof(fd) && n_rows < MAX_ROWS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 8 || line.getc(0) == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          inst, pc, wb, mem, ex, allow, valid, allowin, chk,
                          src1, src2, dest, taken, target);
            if (cnt != 14) begin
                n_errors++;
                $display("pattern row %0d is malformed", n_rows);
                continue;
            end
            p_inst[n_rows]   = inst;
            p_pc[n_rows]     = pc;
            p_wb[n_rows]     = wb;
            p_mem[n_rows]    = mem;
            p_ex[n_rows]     = ex;
            p_allow[n_rows]  = allow[0];
            e_valid[n_rows]  = valid[0];
            e_allow[n_rows]  = allowin[0];
            e_chk[n_rows]    = chk;
            e_src1[n_rows]   = src1;
            e_src2[n_rows]   = src2;
            e_dest[n_rows]   = dest[4:0];
            e_taken[n_rows]  = taken[0];
            e_target[n_rows] = target;
            n_rows++;
        end
        $fclose(fd);
    endtask

    // fill r1..r31 through the write-back port
    task automatic preload_regs();
        for (int i = 1; i < NUM_REGS; i++) begin
            @(negedge clk);
            i_wb_fwd = {1'b1, REG_AW'(i), reg_init(i)};
        end
        @(negedge clk);
        i_wb_fwd = '0;
    endtask

    task automatic apply_row(input int r);
        i_if_valid   = (p_inst[r] != 32'h0);
        i_if_pkt     = {p_inst[r], p_pc[r]};
        i_wb_fwd     = p_wb[r];
        i_mem_fwd    = p_mem[r];
        i_ex_fwd     = p_ex[r];
        i_ex_allowin = p_allow[r];
    endtask

    task automatic check_row(input int r);
        logic held;
        held = e_valid[r] && !e_allow[r];
        check_value("o_id_to_ex_valid", 32'(o_id_to_ex_valid), 32'(e_valid[r]));
        check_value("o_id_allowin", 32'(o_id_allowin), 32'(e_allow[r]));
        check_value("o_br_taken", 32'(o_br_taken), 32'(e_taken[r]));
        if (e_chk[r] != 0) begin
            check_value("pc", o_id_to_ex.pc, stage_pc);
        end
        if (e_chk[r] & CHK_ALU) begin
            check_value("alu_src1", o_id_to_ex.alu_src1, e_src1[r]);
            check_value("alu_src2", o_id_to_ex.alu_src2, e_src2[r]);
            check_value("dest", 32'(o_id_to_ex.dest), 32'(e_dest[r]));
        end
        if (e_chk[r] & CHK_BR) begin
            check_value("o_br_target", o_br_target, e_target[r]);
        end
        // under back-pressure the packet must not move
        if (held && prev_held) begin
            n_checks++;
            if (o_id_to_ex !== prev_pkt) begin
                n_errors++;
                $display("[ERROR] %0t o_id_to_ex got %h expected %h",
                         $time, o_id_to_ex, prev_pkt);
            end
        end
        prev_pkt  = o_id_to_ex;
        prev_held = held;
        // accepted and not on the wrong path
        if (p_inst[r] != 32'h0 && e_allow[r] && !e_taken[r]) begin
            stage_pc = p_pc[r];
        end
    endtask

    initial begin
        resetn       = 1'b0;
        i_if_valid   = 1'b0;
        i_if_pkt     = '0;
        i_ex_allowin = 1'b1;
        i_wb_fwd     = '0;
        i_mem_fwd    = '0;
        i_ex_fwd     = '0;
        n_rows       = 0;
        n_checks     = 0;
        n_errors     = 0;
        rows_loaded  = 1'b0;
        prev_pkt     = '0;
        prev_held    = 1'b0;
        stage_pc     = '0;
        load_patterns();
        rows_loaded = 1'b1;
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        #(CLK_PERIOD/4);
        check_value("o_id_to_ex_valid", 32'(o_id_to_ex_valid), 32'h0);
        check_value("o_br_taken", 32'(o_br_taken), 32'h0);
        check_value("o_id_allowin", 32'(o_id_allowin), 32'h1);
        preload_regs();
        for (int r = 0; r < n_rows; r++) begin
            @(negedge clk);
            apply_row(r);
            #(CLK_PERIOD/4);
            check_row(r);
        end
        @(negedge clk);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && n_rows > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (rows_loaded);
        #((n_rows + 16) * 10 * CLK_PERIOD);
        $display("timeout, the run did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: verification/decode_patterns.txt
# inst pc wb{we,waddr,wdata} mem{we,waddr,wdata} ex{lp,we,waddr,wdata} ex_allowin
# exp_valid exp_allowin chk(1=alu,2=br) exp_src1 exp_src2 exp_dest exp_taken exp_target
00100824 1c000000 0000000000 0000000000 0000000000 1 0 1 0 00000000 00000000 00 0 00000000
00110ca6 1c000004 0000000000 0000000000 0000000000 1 1 1 1 09090909 12121212 04 0 00000000
00102408 1c000008 25cccc0003 25bbbb0002 25aaaa0001 1 1 1 1 aaaa0001 1b1b1b1b 06 0 00000000
02bff06a 1c00000c 20dead0002 20dead0001 20dead0000 1 1 1 1 00000000 51515151 08 0 00000000
0363c04b 1c000010 0000000000 0000000000 0000000000 1 1 1 1 1b1b1b1b fffffffc 0a 0 00000000
1500002c 1c000014 0000000000 0000000000 0000000000 1 1 1 1 12121212 000008f0 0b 0 00000000
54004000 1c000018 0000000000 0000000000 0000000000 1 1 1 1 09090909 80001000 0c 0 00000000
00100824 1c00001c 0000000000 0000000000 0000000000 1 1 1 3 1c000018 00000004 01 1 1c000058
5bfff821 1c000020 0000000000 0000000000 0000000000 1 0 1 0 00000000 00000000 00 0 00000000
00100824 1c000024 0000000000 0000000000 0000000000 1 1 1 2 00000000 00000000 00 1 1c000018
5c001021 1c000028 0000000000 0000000000 0000000000 1 0 1 0 00000000 00000000 00 0 00000000
600021e1 1c00002c 0000000000 0000000000 0000000000 1 1 1 2 00000000 00000000 00 0 1c000038
00100824 1c000030 0000000000 0000000000 0000000000 1 1 1 2 00000000 00000000 00 1 1c00004c
680021e1 1c000034 0000000000 0000000000 0000000000 1 0 1 0 00000000 00000000 00 0 00000000
64000c2f 1c000038 0000000000 0000000000 0000000000 1 1 1 2 00000000 00000000 00 0 1c000054
00100824 1c00003c 0000000000 0000000000 0000000000 1 1 1 2 00000000 00000000 00 1 1c000044
6c000c2f 1c000040 0000000000 0000000000 0000000000 1 0 1 0 00000000 00000000 00 0 00000000
4c004041 1c000044 0000000000 0000000000 0000000000 1 1 1 2 00000000 00000000 00 0 1c00004c
00100824 1c000048 0000000000 0000000000 0000000000 1 1 1 3 1c000044 00000004 01 1 12121252
53fff3ff 1c00004c 0000000000 0000000000 0000000000 1 0 1 0 00000000 00000000 00 0 00000000
00100824 1c000050 0000000000 0000000000 0000000000 1 1 1 2 00000000 00000000 00 1 1c00003c
0010088d 1c000054 0000000000 0000000000 0000000000 1 0 1 0 00000000 00000000 00 0 00000000
03848c0e 1c000058 0000000000 0000000000 6444440000 1 0 0 0 00000000 00000000 00 0 00000000
03848c0e 1c000058 0000000000 0000000000 6444440000 1 0 0 0 00000000 00000000 00 0 00000000
03848c0e 1c000058 0000000000 0000000000 2444440000 1 1 1 1 44440000 12121212 0d 0 00000000
00100824 1c00005c 0000000000 0000000000 0000000000 0 1 0 1 00000000 00000123 0e 0 00000000
00100824 1c00005c 0000000000 0000000000 0000000000 0 1 0 1 00000000 00000123 0e 0 00000000
00100824 1c00005c 0000000000 0000000000 0000000000 1 1 1 1 00000000 00000123 0e 0 00000000
00000000 1c000060 0000000000 0000000000 0000000000 1 1 1 1 09090909 12121212 04 0 00000000
00000000 1c000060 0000000000 0000000000 0000000000 1 0 1 0 00000000 00000000 00 0 00000000

// File: sim.f
hw/decode_pkg.sv
hw/stage_ctrl.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_bypass.sv
hw/branch_unit.sv
hw/decode_stage_top.sv
verification/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - hw/decode_pkg.sv
  - hw/stage_ctrl.sv
  - hw/inst_decoder.sv
  - hw/regfile.sv
  - hw/operand_bypass.sv
  - hw/branch_unit.sv
  - hw/decode_stage_top.sv
  - target: simulation
    files:
      - verification/tb_decode_stage.sv
